//--- sim.f
source/gat_pkg.sv
source/gat_bram.sv
source/spmm_engine.sv
source/wh_fifo.sv
source/feature_writer.sv
source/gat_top.sv
source/gat_top_wrapper.sv
sim/gat_tb.sv

//--- sim/gat_tb.sv
`default_nettype none

module gat_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 20;
  localparam int DRIVE_DELAY = 1;
  localparam int RESET_CYCLES = 4;
  localparam int NODES       = gat_pkg::TOTAL_NODES;
  localparam int FOUT        = gat_pkg::NUM_FEATURE_OUT;
  localparam int FIN         = gat_pkg::NUM_FEATURE_IN;
  localparam int H_DEPTH     = gat_pkg::H_NUM_SPARSE_DATA;
  localparam int MAX_ROW_LEN = 4;
  // Two runs of about 144 load writes, 16 * (1 + 4 * 6 + 5) engine cycles
  // and 128 readback cycles each, with a wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                                        clk;
  logic                                        rst_n;
  logic                                        gat_ready;
  logic [gat_pkg::TOP_WIDTH-1:0]               gat_debug_1;
  logic                                        h_data_bram_load_done;
  logic                                        h_node_info_bram_load_done;
  logic                                        wgt_bram_load_done;
  logic [gat_pkg::TOP_WIDTH-1:0]               h_data_bram_din;
  logic                                        h_data_bram_ena;
  logic                                        h_data_bram_wea;
  logic [gat_pkg::H_DATA_ADDR_W+1:0]           h_data_bram_addra;
  logic [gat_pkg::TOP_WIDTH-1:0]               h_node_info_bram_din;
  logic                                        h_node_info_bram_ena;
  logic                                        h_node_info_bram_wea;
  logic [gat_pkg::NODE_INFO_ADDR_W+1:0]        h_node_info_bram_addra;
  logic [gat_pkg::TOP_WIDTH-1:0]               wgt_bram_din;
  logic                                        wgt_bram_ena;
  logic                                        wgt_bram_wea;
  logic [gat_pkg::WEIGHT_ADDR_W+1:0]           wgt_bram_addra;
  logic [gat_pkg::NEW_FEATURE_ADDR_W+1:0]      feat_bram_addrb;
  logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]       feat_bram_dout;

  integer seed;
  integer cycle_count;
  integer num_entries;
  integer h_val    [H_DEPTH];
  integer h_col    [H_DEPTH];
  integer row_len  [NODES];
  integer wgt      [FIN*FOUT];
  integer expected [NODES*FOUT];

  gat_top_wrapper dut_i (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .gat_ready                  (gat_ready),
    .gat_debug_1                (gat_debug_1),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .h_data_bram_din            (h_data_bram_din),
    .h_data_bram_ena            (h_data_bram_ena),
    .h_data_bram_wea            (h_data_bram_wea),
    .h_data_bram_addra          (h_data_bram_addra),
    .h_node_info_bram_din       (h_node_info_bram_din),
    .h_node_info_bram_ena       (h_node_info_bram_ena),
    .h_node_info_bram_wea       (h_node_info_bram_wea),
    .h_node_info_bram_addra     (h_node_info_bram_addra),
    .wgt_bram_din               (wgt_bram_din),
    .wgt_bram_ena               (wgt_bram_ena),
    .wgt_bram_wea               (wgt_bram_wea),
    .wgt_bram_addra             (wgt_bram_addra),
    .feat_bram_addrb            (feat_bram_addrb),
    .feat_bram_dout             (feat_bram_dout)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Watchdog
  initial cycle_count = 0;
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped by the watchdog");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] exp);
    if (actual !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
  endtask

  // ============================================================
  // Random data and the reference model
  // ============================================================
  task automatic make_data();
    integer n;
    integer e;
    integer i;
    integer f;
    num_entries = 0;
    for (i = 0; i < H_DEPTH; i++) begin
      h_val[i] = 0;
      h_col[i] = 0;
    end
    for (n = 0; n < NODES; n++) begin
      row_len[n] = {$random(seed)} % (MAX_ROW_LEN + 1);
      // Node 0 empty, node 1 saturates high, node 2 goes far negative
      if (n == 0) row_len[n] = 0;
      if (n == 1 || n == 2) row_len[n] = MAX_ROW_LEN;
      for (e = 0; e < row_len[n]; e++) begin
        if (n == 1) begin
          h_val[num_entries] = 127;
          h_col[num_entries] = 0;
        end else if (n == 2) begin
          h_val[num_entries] = -128;
          h_col[num_entries] = 0;
        end else begin
          h_val[num_entries] = ({$random(seed)} % 256) - 128;
          h_col[num_entries] = {$random(seed)} % FIN;
        end
        num_entries = num_entries + 1;
      end
    end
    for (i = 0; i < FIN*FOUT; i++) begin
      wgt[i] = ({$random(seed)} % 256) - 128;
    end
    for (f = 0; f < FOUT; f++) begin
      wgt[f] = 127;
    end
  endtask

  task automatic compute_expected();
    integer n;
    integer f;
    integer e;
    integer ptr;
    integer sum;
    ptr = 0;
    for (n = 0; n < NODES; n++) begin
      for (f = 0; f < FOUT; f++) begin
        sum = 0;
        for (e = 0; e < row_len[n]; e++) begin
          sum = sum + h_val[ptr+e] * wgt[h_col[ptr+e]*FOUT + f];
        end
        if (sum < 0) sum = 0;
        if (sum > gat_pkg::FEATURE_MAX) sum = gat_pkg::FEATURE_MAX;
        expected[n*FOUT + f] = sum;
      end
      ptr = ptr + row_len[n];
    end
  endtask

  // ============================================================
  // Host side
  // ============================================================
  task automatic host_write(input int mem_sel, input int word_addr, input logic [31:0] data);
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("gat_ready", {31'b0, gat_ready}, 32'h0);
    h_data_bram_ena      = (mem_sel == 0);
    h_data_bram_wea      = (mem_sel == 0);
    h_node_info_bram_ena = (mem_sel == 1);
    h_node_info_bram_wea = (mem_sel == 1);
    wgt_bram_ena         = (mem_sel == 2);
    wgt_bram_wea         = (mem_sel == 2);
    case (mem_sel)
      0: begin
        h_data_bram_addra = word_addr * 4;
        h_data_bram_din   = data;
      end
      1: begin
        h_node_info_bram_addra = word_addr * 4;
        h_node_info_bram_din   = data;
      end
      default: begin
        wgt_bram_addra = word_addr * 4;
        wgt_bram_din   = data;
      end
    endcase
  endtask

  task automatic load_memories();
    integer i;
    logic [7:0] val_byte;
    logic [3:0] col_bits;
    for (i = 0; i < H_DEPTH; i++) begin
      val_byte = h_val[i][7:0];
      col_bits = h_col[i][3:0];
      // H word holds the value above the column index
      host_write(0, i, {20'b0, val_byte, col_bits});
    end
    for (i = 0; i < NODES; i++) begin
      host_write(1, i, row_len[i]);
    end
    for (i = 0; i < FIN*FOUT; i++) begin
      host_write(2, i, {24'b0, wgt[i][7:0]});
    end
    @(posedge clk);
    #DRIVE_DELAY;
    h_data_bram_ena      = 1'b0;
    h_data_bram_wea      = 1'b0;
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;
    wgt_bram_ena         = 1'b0;
    wgt_bram_wea         = 1'b0;
    check_value("gat_ready", {31'b0, gat_ready}, 32'h0);
  endtask

  task automatic run_once();
    integer a;
    apply_reset();
    check_value("gat_ready", {31'b0, gat_ready}, 32'h0);
    make_data();
    compute_expected();
    load_memories();
    @(posedge clk);
    #DRIVE_DELAY;
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    wgt_bram_load_done         = 1'b1;
    // Bounded by the watchdog
    while (gat_ready !== 1'b1) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    check_value("gat_debug_1", gat_debug_1, NODES);
    // Read data returns one clock after the address
    for (a = 0; a < NODES*FOUT; a++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      feat_bram_addrb = a * 4;
      @(posedge clk);
      #DRIVE_DELAY;
      check_value($sformatf("feat_bram_dout[%0d]", a), feat_bram_dout, expected[a]);
    end
  endtask

  initial begin
    seed                       = 7968;
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    feat_bram_addrb            = '0;
    // Second run checks that the start flag and pointers reset
    run_once();
    run_once();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/feature_writer.sv
`default_nettype none

module feature_writer (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire gat_pkg::wh_row_t                    head,
  input  wire logic                                empty,
  output logic                                     pop,
  input  wire logic                                producer_done,
  output logic                                     feat_wr_en,
  output logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0]   feat_wr_addr,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]    feat_wr_data,
  output logic [gat_pkg::NODE_CNT_WIDTH-1:0]       node_count,
  output logic                                     ready
);

  gat_pkg::wh_row_t                   row_q;
  logic                               busy;
  logic [gat_pkg::FEAT_IDX_WIDTH-1:0] f_idx;
  logic                               last_write;
  gat_pkg::wh_data_t                  elem;

  // Next row is taken in the cycle of the last write
  assign last_write = busy && (&f_idx);
  assign pop        = !empty && (!busy || last_write);

  assign feat_wr_en   = busy;
  // node * NUM_FEATURE_OUT + feature
  assign feat_wr_addr = {row_q.node, f_idx};
  assign elem         = row_q.acc[f_idx];

  // ============================================================
  // ReLU and saturation
  // ============================================================
  always_comb begin
    if (elem < 0) begin
      feat_wr_data = '0;
    end else if (elem > gat_pkg::FEATURE_MAX) begin
      feat_wr_data = gat_pkg::NEW_FEATURE_WIDTH'(gat_pkg::FEATURE_MAX);
    end else begin
      feat_wr_data = gat_pkg::NEW_FEATURE_WIDTH'(elem);
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      row_q <= head;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      f_idx      <= '0;
      node_count <= '0;
      ready      <= 1'b0;
    end else begin
      if (pop) begin
        busy <= 1'b1;
      end else if (last_write) begin
        busy <= 1'b0;
      end
      // Returns to zero after the last feature
      if (busy) begin
        f_idx <= f_idx + 1'b1;
      end
      if (last_write) begin
        node_count <= node_count + 1'b1;
      end
      if (producer_done && empty && !busy) begin
        ready <= 1'b1;
      end
    end
  end

  // Every node has passed through engine, FIFO and writer
  assert property (@(posedge clk) disable iff (!rst_n)
    ready |-> (node_count == gat_pkg::NODE_CNT_WIDTH'(gat_pkg::TOTAL_NODES)));

endmodule

`default_nettype wire

//--- source/gat_bram.sv
`default_nettype none

module gat_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 64
) (
  input  wire logic                     clk,
  input  wire logic                     wr_en,
  input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
  input  wire logic [WIDTH-1:0]         wr_data,
  input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]              rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read returns old data on a same-address write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- source/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ============================================================
  // Problem size
  // ============================================================
  localparam int TOP_WIDTH         = 32;
  localparam int DATA_WIDTH        = 8;
  localparam int NUM_FEATURE_IN    = 16;
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int TOTAL_NODES       = 16;
  localparam int H_NUM_SPARSE_DATA = 64;
  localparam int WH_DATA_WIDTH     = 20;
  localparam int NEW_FEATURE_WIDTH = 32;
  localparam int FIFO_DEPTH        = 4;

  // Clamp level for a feature, well inside the accumulator range
  localparam int FEATURE_MAX = 32767;

  // Derived widths
  localparam int COL_IDX_WIDTH  = $clog2(NUM_FEATURE_IN);
  localparam int ROW_LEN_WIDTH  = $clog2(NUM_FEATURE_IN + 1);
  localparam int NODE_IDX_WIDTH = $clog2(TOTAL_NODES);
  localparam int NODE_CNT_WIDTH = $clog2(TOTAL_NODES + 1);
  localparam int FEAT_IDX_WIDTH = $clog2(NUM_FEATURE_OUT);
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

  // ============================================================
  // Memory depths and word address widths
  // ============================================================
  localparam int WEIGHT_DEPTH      = NUM_FEATURE_IN * NUM_FEATURE_OUT;
  localparam int NEW_FEATURE_DEPTH = TOTAL_NODES * NUM_FEATURE_OUT;

  localparam int H_DATA_ADDR_W      = $clog2(H_NUM_SPARSE_DATA);
  localparam int NODE_INFO_ADDR_W   = $clog2(TOTAL_NODES);
  localparam int WEIGHT_ADDR_W      = $clog2(WEIGHT_DEPTH);
  localparam int NEW_FEATURE_ADDR_W = $clog2(NEW_FEATURE_DEPTH);

  // ============================================================
  // Shared types
  // ============================================================
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_data_t;

  // One nonzero of H, value in the upper bits
  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] value;
    logic [COL_IDX_WIDTH-1:0]     col_idx;
  } h_entry_t;

  // Nonzero count of one node row
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0] row_len;
  } node_info_t;

  // Finished WH row on its way to the feature writer
  typedef struct packed {
    logic [NODE_IDX_WIDTH-1:0]       node;
    wh_data_t [NUM_FEATURE_OUT-1:0] acc;
  } wh_row_t;

endpackage

`default_nettype wire

//--- source/gat_top.sv
`default_nettype none

module gat_top (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  output logic                                      gat_ready,
  output logic [gat_pkg::NODE_CNT_WIDTH-1:0]        gat_debug_1,
  input  wire logic                                 h_data_bram_load_done,
  input  wire logic                                 h_node_info_bram_load_done,
  input  wire logic                                 wgt_bram_load_done,
  input  wire gat_pkg::h_entry_t                    h_data_bram_din,
  input  wire logic                                 h_data_bram_ena,
  input  wire logic                                 h_data_bram_wea,
  input  wire logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_data_bram_addra,
  input  wire gat_pkg::node_info_t                  h_node_info_bram_din,
  input  wire logic                                 h_node_info_bram_ena,
  input  wire logic                                 h_node_info_bram_wea,
  input  wire logic [gat_pkg::NODE_INFO_ADDR_W-1:0] h_node_info_bram_addra,
  input  wire logic [gat_pkg::DATA_WIDTH-1:0]       wgt_bram_din,
  input  wire logic                                 wgt_bram_ena,
  input  wire logic                                 wgt_bram_wea,
  input  wire logic [gat_pkg::WEIGHT_ADDR_W-1:0]    wgt_bram_addra,
  input  wire logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0] feat_bram_addrb,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]     feat_bram_dout
);

  logic                                    all_loaded;
  logic                                    started;
  logic                                    start;
  logic [gat_pkg::NODE_INFO_ADDR_W-1:0]    node_info_addr;
  gat_pkg::node_info_t                     node_info;
  logic [gat_pkg::H_DATA_ADDR_W-1:0]       h_addr;
  gat_pkg::h_entry_t                       h_entry;
  logic [gat_pkg::WEIGHT_ADDR_W-1:0]       wgt_addr;
  logic signed [gat_pkg::DATA_WIDTH-1:0]   wgt_data;
  logic                                    push;
  gat_pkg::wh_row_t                        push_row;
  logic                                    full;
  logic                                    pop;
  gat_pkg::wh_row_t                        head;
  logic                                    empty;
  logic                                    producer_done;
  logic                                    feat_wr_en;
  logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0]  feat_wr_addr;
  logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]   feat_wr_data;

  // Start once per reset, when all three loads are done
  assign all_loaded = h_data_bram_load_done && h_node_info_bram_load_done &&
                      wgt_bram_load_done;
  assign start      = all_loaded && !started;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (all_loaded) begin
      started <= 1'b1;
    end
  end

  // ============================================================
  // Memories
  // ============================================================
  gat_bram #(.WIDTH($bits(gat_pkg::h_entry_t)), .DEPTH(gat_pkg::H_NUM_SPARSE_DATA)) u_h_data (
    .clk     (clk),
    .wr_en   (h_data_bram_ena && h_data_bram_wea),
    .wr_addr (h_data_bram_addra),
    .wr_data (h_data_bram_din),
    .rd_addr (h_addr),
    .rd_data (h_entry)
  );

  gat_bram #(.WIDTH($bits(gat_pkg::node_info_t)), .DEPTH(gat_pkg::TOTAL_NODES)) u_node_info (
    .clk     (clk),
    .wr_en   (h_node_info_bram_ena && h_node_info_bram_wea),
    .wr_addr (h_node_info_bram_addra),
    .wr_data (h_node_info_bram_din),
    .rd_addr (node_info_addr),
    .rd_data (node_info)
  );

  gat_bram #(.WIDTH(gat_pkg::DATA_WIDTH), .DEPTH(gat_pkg::WEIGHT_DEPTH)) u_weight (
    .clk     (clk),
    .wr_en   (wgt_bram_ena && wgt_bram_wea),
    .wr_addr (wgt_bram_addra),
    .wr_data (wgt_bram_din),
    .rd_addr (wgt_addr),
    .rd_data (wgt_data)
  );

  gat_bram #(.WIDTH(gat_pkg::NEW_FEATURE_WIDTH), .DEPTH(gat_pkg::NEW_FEATURE_DEPTH)) u_feature (
    .clk     (clk),
    .wr_en   (feat_wr_en),
    .wr_addr (feat_wr_addr),
    .wr_data (feat_wr_data),
    .rd_addr (feat_bram_addrb),
    .rd_data (feat_bram_dout)
  );

  // ============================================================
  // Producer, buffer, consumer
  // ============================================================
  spmm_engine u_spmm_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .node_info_addr (node_info_addr),
    .node_info      (node_info),
    .h_addr         (h_addr),
    .h_entry        (h_entry),
    .wgt_addr       (wgt_addr),
    .wgt_data       (wgt_data),
    .push           (push),
    .push_row       (push_row),
    .full           (full),
    .done           (producer_done)
  );

  wh_fifo u_wh_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (push),
    .push_row (push_row),
    .full     (full),
    .pop      (pop),
    .head     (head),
    .empty    (empty)
  );

  feature_writer u_feature_writer (
    .clk           (clk),
    .rst_n         (rst_n),
    .head          (head),
    .empty         (empty),
    .pop           (pop),
    .producer_done (producer_done),
    .feat_wr_en    (feat_wr_en),
    .feat_wr_addr  (feat_wr_addr),
    .feat_wr_data  (feat_wr_data),
    .node_count    (gat_debug_1),
    .ready         (gat_ready)
  );

endmodule

`default_nettype wire

//--- source/gat_top_wrapper.sv
`default_nettype none

module gat_top_wrapper (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,
  output logic                                        gat_ready,
  output logic [gat_pkg::TOP_WIDTH-1:0]               gat_debug_1,
  input  wire logic                                   h_data_bram_load_done,
  input  wire logic                                   h_node_info_bram_load_done,
  input  wire logic                                   wgt_bram_load_done,
  input  wire logic [gat_pkg::TOP_WIDTH-1:0]          h_data_bram_din,
  input  wire logic                                   h_data_bram_ena,
  input  wire logic                                   h_data_bram_wea,
  input  wire logic [gat_pkg::H_DATA_ADDR_W+1:0]      h_data_bram_addra,
  input  wire logic [gat_pkg::TOP_WIDTH-1:0]          h_node_info_bram_din,
  input  wire logic                                   h_node_info_bram_ena,
  input  wire logic                                   h_node_info_bram_wea,
  input  wire logic [gat_pkg::NODE_INFO_ADDR_W+1:0]   h_node_info_bram_addra,
  input  wire logic [gat_pkg::TOP_WIDTH-1:0]          wgt_bram_din,
  input  wire logic                                   wgt_bram_ena,
  input  wire logic                                   wgt_bram_wea,
  input  wire logic [gat_pkg::WEIGHT_ADDR_W+1:0]      wgt_bram_addra,
  input  wire logic [gat_pkg::NEW_FEATURE_ADDR_W+1:0] feat_bram_addrb,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]       feat_bram_dout
);

  logic [gat_pkg::NODE_CNT_WIDTH-1:0] node_count;

  assign gat_debug_1 = gat_pkg::TOP_WIDTH'(node_count);

  // Byte addresses drop bits [1:0], data keeps the low bits only
  gat_top u_gat_top (
    .clk                        (clk),
    .rst_n                      (rst_n),
    .gat_ready                  (gat_ready),
    .gat_debug_1                (node_count),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .h_data_bram_din            (h_data_bram_din[$bits(gat_pkg::h_entry_t)-1:0]),
    .h_data_bram_ena            (h_data_bram_ena),
    .h_data_bram_wea            (h_data_bram_wea),
    .h_data_bram_addra          (h_data_bram_addra[gat_pkg::H_DATA_ADDR_W+1:2]),
    .h_node_info_bram_din       (h_node_info_bram_din[$bits(gat_pkg::node_info_t)-1:0]),
    .h_node_info_bram_ena       (h_node_info_bram_ena),
    .h_node_info_bram_wea       (h_node_info_bram_wea),
    .h_node_info_bram_addra     (h_node_info_bram_addra[gat_pkg::NODE_INFO_ADDR_W+1:2]),
    .wgt_bram_din               (wgt_bram_din[gat_pkg::DATA_WIDTH-1:0]),
    .wgt_bram_ena               (wgt_bram_ena),
    .wgt_bram_wea               (wgt_bram_wea),
    .wgt_bram_addra             (wgt_bram_addra[gat_pkg::WEIGHT_ADDR_W+1:2]),
    .feat_bram_addrb            (feat_bram_addrb[gat_pkg::NEW_FEATURE_ADDR_W+1:2]),
    .feat_bram_dout             (feat_bram_dout)
  );

endmodule

`default_nettype wire

//--- source/spmm_engine.sv
`default_nettype none

module spmm_engine (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  start,
  output logic [gat_pkg::NODE_INFO_ADDR_W-1:0]       node_info_addr,
  input  wire gat_pkg::node_info_t                   node_info,
  output logic [gat_pkg::H_DATA_ADDR_W-1:0]          h_addr,
  input  wire gat_pkg::h_entry_t                     h_entry,
  output logic [gat_pkg::WEIGHT_ADDR_W-1:0]          wgt_addr,
  input  wire logic signed [gat_pkg::DATA_WIDTH-1:0] wgt_data,
  output logic                                       push,
  output gat_pkg::wh_row_t                           push_row,
  input  wire logic                                  full,
  output logic                                       done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_INFO,
    S_LEN,
    S_HREAD,
    S_WREAD,
    S_ACC,
    S_PUSH,
    S_DONE
  } state_t;

  state_t                                          state;
  logic [gat_pkg::NODE_IDX_WIDTH-1:0]              node_idx;
  logic [gat_pkg::H_DATA_ADDR_W-1:0]               h_ptr;
  logic [gat_pkg::ROW_LEN_WIDTH-1:0]               remaining;
  logic [gat_pkg::FEAT_IDX_WIDTH-1:0]              f_idx;
  logic                                            acc_en;
  logic [gat_pkg::FEAT_IDX_WIDTH-1:0]              acc_idx;
  gat_pkg::wh_data_t [gat_pkg::NUM_FEATURE_OUT-1:0] acc;
  logic signed [2*gat_pkg::DATA_WIDTH-1:0]         product;

  assign node_info_addr = node_idx;
  assign h_addr         = h_ptr;
  // W row of the column index, one word per output feature
  assign wgt_addr       = {h_entry.col_idx, f_idx};
  assign product        = h_entry.value * wgt_data;

  assign push     = (state == S_PUSH) && !full;
  assign push_row = '{node: node_idx, acc: acc};
  assign done     = (state == S_DONE);

  // ============================================================
  // Node and entry sequencing
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      node_idx  <= '0;
      h_ptr     <= '0;
      remaining <= '0;
      f_idx     <= '0;
      acc_en    <= 1'b0;
      acc_idx   <= '0;
    end else begin
      // Weight data lags its address by one cycle
      acc_en  <= (state == S_WREAD);
      acc_idx <= f_idx;
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_INFO;
          end
        end
        S_INFO: state <= S_LEN;
        S_LEN: begin
          remaining <= node_info.row_len;
          state     <= (node_info.row_len == '0) ? S_PUSH : S_HREAD;
        end
        S_HREAD: state <= S_WREAD;
        S_WREAD: begin
          // f_idx wraps back to zero after the last feature
          f_idx <= f_idx + 1'b1;
          if (&f_idx) begin
            state <= S_ACC;
          end
        end
        S_ACC: begin
          h_ptr     <= h_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          state     <= (remaining == 1) ? S_PUSH : S_HREAD;
        end
        S_PUSH: begin
          if (!full) begin
            node_idx <= node_idx + 1'b1;
            if (node_idx == gat_pkg::NODE_IDX_WIDTH'(gat_pkg::TOTAL_NODES - 1)) begin
              state <= S_DONE;
            end else begin
              state <= S_INFO;
            end
          end
        end
        S_DONE:  state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Accumulators, cleared at the start of each node
  always_ff @(posedge clk) begin
    if (state == S_INFO) begin
      acc <= '0;
    end else if (acc_en) begin
      acc[acc_idx] <= acc[acc_idx] + product;
    end
  end

  // Back-pressure from the FIFO holds the row here
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_PUSH && full) |=> (state == S_PUSH && $stable(push_row)));

endmodule

`default_nettype wire

//--- source/wh_fifo.sv
`default_nettype none

module wh_fifo (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push,
  input  wire gat_pkg::wh_row_t push_row,
  output logic                  full,
  input  wire logic             pop,
  output gat_pkg::wh_row_t      head,
  output logic                  empty
);

  gat_pkg::wh_row_t                   mem [gat_pkg::FIFO_DEPTH];
  logic [gat_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [gat_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [gat_pkg::FIFO_PTR_WIDTH:0]   count;

  assign full  = (count == gat_pkg::FIFO_DEPTH);
  assign empty = (count == 0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_row;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Both neighbours must respect the levels
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);
  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

endmodule

`default_nettype wire
